//--- periph_pkg.sv
// Shared bus widths, region map, request and time types for the peripheral block
`default_nettype none

package periph_pkg;

    // ------------------------------------------------------------
    // Bus widths
    // ------------------------------------------------------------
    localparam int AddrWidth = 32;
    localparam int DataWidth = 64;
    localparam int StrbWidth = DataWidth / 8;   // One enable per byte lane

    typedef logic [AddrWidth-1:0] addr_t;
    typedef logic [DataWidth-1:0] data_t;
    typedef logic [StrbWidth-1:0] strb_t;

    // One request on the strobe bus, valid while req_i is high
    typedef struct packed {
        logic  we;      // 1 = write
        addr_t addr;    // Byte address
        strb_t be;
        data_t wdata;
    } mem_req_t;

    // ------------------------------------------------------------
    // Region map
    // ------------------------------------------------------------
    // Lengths are powers of two so a region matches on masked address
    localparam addr_t BootBase   = 32'h0001_0000;
    localparam addr_t BootLength = 32'h0001_0000;
    localparam addr_t GpioBase   = 32'h4000_0000;
    localparam addr_t GpioLength = 32'h0000_1000;

    typedef enum logic [1:0] {
        REGION_BOOT,
        REGION_GPIO,
        REGION_NONE
    } region_e;

    // Marker read back from unmapped space
    localparam data_t ErrorData = 64'h0000_0000_dead_beef;

    // ------------------------------------------------------------
    // GPIO register offsets, address bits 5..3
    // ------------------------------------------------------------
    typedef logic [2:0] gpio_off_t;

    localparam gpio_off_t GpioRegLeds = 3'd0;   // Write LEDs, read DIP switches
    localparam gpio_off_t GpioRegRtc  = 3'd7;   // Read time, write loads it

    // ------------------------------------------------------------
    // Real-time clock
    // ------------------------------------------------------------
    localparam int RtcTickBits = 26;
    localparam int RtcSecBits  = 38;

    // Fills exactly one data word
    typedef struct packed {
        logic [RtcSecBits-1:0]  seconds;
        logic [RtcTickBits-1:0] ticks;
    } rtc_time_t;

endpackage

`default_nettype wire

//--- rtc_timer.sv
// Real-time clock with sub-second ticks and a seconds count, loadable from software
`default_nettype none
`timescale 1ns/1ns

module rtc_timer #(
    parameter int TicksPerSecond = 50_000_000  // At most 2**RtcTickBits
) (
    input  wire logic                  clk_i,
    input  wire logic                  arst_n_i,
    input  wire logic                  load_i,
    input  wire periph_pkg::rtc_time_t load_value_i,
    output periph_pkg::rtc_time_t      time_o
);

    // Last tick value before rolling into the next second
    localparam logic [periph_pkg::RtcTickBits-1:0] TickMax =
        periph_pkg::RtcTickBits'(TicksPerSecond - 1);

    periph_pkg::rtc_time_t time_q;

    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            time_q <= '0;
        end
        else if (load_i)
        begin
            time_q <= load_value_i;             // Both fields replaced together
        end
        else if (time_q.ticks == TickMax)
        begin
            time_q.ticks   <= '0;
            time_q.seconds <= time_q.seconds + 1'b1;
        end
        else
        begin
            time_q.ticks <= time_q.ticks + 1'b1;
        end
    end

    assign time_o = time_q;

endmodule

`default_nettype wire

//--- boot_ram.sv
// Boot memory on the peripheral bus, byte-enable writes and one-cycle registered reads
`default_nettype none
`timescale 1ns/1ns

module boot_ram #(
    parameter int BootWords = 512           // Depth in 64-bit words, power of two
) (
    input  wire logic                 clk_i,
    input  wire logic                 sel_i,
    input  wire periph_pkg::mem_req_t req_payload_i,
    output periph_pkg::data_t         rdata_o
);

    // Byte offset bits inside one data word
    localparam int OffsetBits = $clog2(periph_pkg::StrbWidth);
    localparam int IndexBits  = $clog2(BootWords);

    periph_pkg::data_t        mem [BootWords];
    logic [IndexBits-1:0]     word_idx;

    // Upper address bits wrap around the depth
    assign word_idx = req_payload_i.addr[OffsetBits +: IndexBits];

    // ------------------------------------------------------------
    // Write with byte lanes, read registered
    // ------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (sel_i)
        begin
            if (req_payload_i.we)
            begin
                for (int i = 0; i < periph_pkg::StrbWidth; i++)
                begin
                    if (req_payload_i.be[i])
                    begin
                        mem[word_idx][8*i +: 8] <= req_payload_i.wdata[8*i +: 8];
                    end
                end
            end
            rdata_o <= mem[word_idx];       // Old contents on a write
        end
    end

endmodule

`default_nettype wire

//--- gpio_regs.sv
// GPIO register block: LED outputs, DIP switch readback and the RTC register window
`default_nettype none
`timescale 1ns/1ns

module gpio_regs #(
    parameter int TicksPerSecond = 50_000_000
) (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,

    // Bus target side
    input  wire logic                 sel_i,
    input  wire periph_pkg::mem_req_t req_payload_i,
    output periph_pkg::data_t         rdata_o,

    // Board pins
    input  wire logic [7:0]           dip_switches_i,
    output logic      [7:0]           leds_o
);

    periph_pkg::gpio_off_t off_d;
    periph_pkg::gpio_off_t off_q;       // Offset of the request being answered
    logic                  wr_en;
    logic                  rtc_load;
    periph_pkg::rtc_time_t rtc_time;

    assign off_d = req_payload_i.addr[5:3];
    assign wr_en = sel_i && req_payload_i.we;

    // ------------------------------------------------------------
    // Register writes and offset capture
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            leds_o <= '0;
            off_q  <= '0;
        end
        else
        begin
            if (sel_i)
            begin
                off_q <= off_d;
            end
            // LEDs live in byte lane 0 only
            if (wr_en && (off_d == periph_pkg::GpioRegLeds) && req_payload_i.be[0])
            begin
                leds_o <= req_payload_i.wdata[7:0];
            end
        end
    end

    // Timer load lands on the same edge as the write
    assign rtc_load = wr_en && (off_d == periph_pkg::GpioRegRtc);

    rtc_timer #(
        .TicksPerSecond (TicksPerSecond)
    ) rtc_timer_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .load_i         (rtc_load),
        .load_value_i   (periph_pkg::rtc_time_t'(req_payload_i.wdata)),
        .time_o         (rtc_time)
    );

    // ------------------------------------------------------------
    // Read mux, live values in the response cycle
    // ------------------------------------------------------------
    always_comb
    begin
        case (off_q)
            periph_pkg::GpioRegLeds: rdata_o = periph_pkg::DataWidth'(dip_switches_i);
            periph_pkg::GpioRegRtc:  rdata_o = rtc_time;
            default:                 rdata_o = '0;   // Reserved offsets
        endcase
    end

endmodule

`default_nettype wire

//--- bus_decoder.sv
// Address decoder for the peripheral bus; selects a target and returns a one-cycle response
`default_nettype none
`timescale 1ns/1ns

module bus_decoder (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,

    // Request side
    input  wire logic                 req_i,
    input  wire periph_pkg::mem_req_t req_payload_i,

    // Target selects
    output logic                      boot_sel_o,
    output logic                      gpio_sel_o,

    // Target read data, valid in the response cycle
    input  wire periph_pkg::data_t    boot_rdata_i,
    input  wire periph_pkg::data_t    gpio_rdata_i,

    // Response side
    output logic                      rvalid_o,
    output periph_pkg::data_t         rdata_o,
    output logic                      err_o
);

    // Masks that clear the offset bits inside each region
    localparam periph_pkg::addr_t BootMask = ~(periph_pkg::BootLength - 32'd1);
    localparam periph_pkg::addr_t GpioMask = ~(periph_pkg::GpioLength - 32'd1);

    periph_pkg::region_e region_d;
    periph_pkg::region_e region_q;
    logic                rvalid_q;

    // ------------------------------------------------------------
    // Request cycle decode
    // ------------------------------------------------------------
    always_comb
    begin
        if ((req_payload_i.addr & BootMask) == periph_pkg::BootBase)
        begin
            region_d = periph_pkg::REGION_BOOT;
        end
        else if ((req_payload_i.addr & GpioMask) == periph_pkg::GpioBase)
        begin
            region_d = periph_pkg::REGION_GPIO;
        end
        else
        begin
            region_d = periph_pkg::REGION_NONE;  // Unmapped, no target sees it
        end
    end

    assign boot_sel_o = req_i && (region_d == periph_pkg::REGION_BOOT);
    assign gpio_sel_o = req_i && (region_d == periph_pkg::REGION_GPIO);

    // ------------------------------------------------------------
    // Response tracking
    // ------------------------------------------------------------
    always_ff @(posedge clk_i or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            rvalid_q <= 1'b0;
            region_q <= periph_pkg::REGION_NONE;
        end
        else
        begin
            rvalid_q <= req_i;                  // One response per request
            if (req_i)
            begin
                region_q <= region_d;
            end
        end
    end

    // Read data mux in the response cycle
    always_comb
    begin
        case (region_q)
            periph_pkg::REGION_BOOT: rdata_o = boot_rdata_i;
            periph_pkg::REGION_GPIO: rdata_o = gpio_rdata_i;
            default:                 rdata_o = periph_pkg::ErrorData;
        endcase
    end

    assign rvalid_o = rvalid_q;
    assign err_o    = rvalid_q && (region_q == periph_pkg::REGION_NONE);

endmodule

`default_nettype wire

//--- periph_top.sv
// Top of the peripheral block; connects the bus decoder to the boot RAM and the GPIO registers
`default_nettype none
`timescale 1ns/1ns

module periph_top #(
    parameter int TicksPerSecond = 50_000_000,
    parameter int BootWords      = 512
) (
    input  wire logic                 clk_i,
    input  wire logic                 arst_n_i,

    // Request bus
    input  wire logic                 req_i,
    input  wire periph_pkg::mem_req_t req_payload_i,

    // Response bus
    output logic                      rvalid_o,
    output periph_pkg::data_t         rdata_o,
    output logic                      err_o,

    // Board pins
    input  wire logic [7:0]           dip_switches_i,
    output logic      [7:0]           leds_o
);

    logic              boot_sel;
    logic              gpio_sel;
    periph_pkg::data_t boot_rdata;
    periph_pkg::data_t gpio_rdata;

    // ------------------------------------------------------------
    // Address decode and response
    // ------------------------------------------------------------
    bus_decoder bus_decoder_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .req_payload_i  (req_payload_i),
        .boot_sel_o     (boot_sel),
        .gpio_sel_o     (gpio_sel),
        .boot_rdata_i   (boot_rdata),
        .gpio_rdata_i   (gpio_rdata),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o),
        .err_o          (err_o)
    );

    // ------------------------------------------------------------
    // Targets, payload is shared
    // ------------------------------------------------------------
    boot_ram #(
        .BootWords      (BootWords)
    ) boot_ram_inst (
        .clk_i          (clk_i),
        .sel_i          (boot_sel),
        .req_payload_i  (req_payload_i),
        .rdata_o        (boot_rdata)
    );

    gpio_regs #(
        .TicksPerSecond (TicksPerSecond)
    ) gpio_regs_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .sel_i          (gpio_sel),
        .req_payload_i  (req_payload_i),
        .rdata_o        (gpio_rdata),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o)
    );

endmodule

`default_nettype wire

//--- tb_periph_top.sv
// Directed testbench for the peripheral block; run it through src.f as top module tb_periph_top
`default_nettype none
`timescale 1ns/1ns

module tb_periph_top;

    localparam int TicksPerSecond = 10;
    localparam int BootWords      = 512;
    localparam int TimeoutCycles  = 2000;
    localparam logic [31:0] LfsrSeed = 32'h30ed87d7;
    localparam logic [31:0] LfsrMask = 32'hb4bcd35c;    // Maximal-length Galois taps

    // What the response of the request in flight must look like
    typedef enum logic [1:0] {
        EXP_WRITE,
        EXP_LOAD,
        EXP_DATA,
        EXP_RTC
    } exp_kind_e;

    typedef struct packed {
        exp_kind_e         kind;
        logic              err;
        periph_pkg::data_t data;
    } expect_t;

    logic                 clk_i;
    logic                 arst_n_i;
    logic                 req_i;
    periph_pkg::mem_req_t req_payload_i;
    logic                 rvalid_o;
    periph_pkg::data_t    rdata_o;
    logic                 err_o;
    logic [7:0]           dip_switches_i;
    logic [7:0]           leds_o;

    int                    error_count;
    int                    cycles;
    logic [31:0]           lfsr_state;
    expect_t               pending;
    periph_pkg::data_t     boot_model [BootWords];
    logic [7:0]            leds_model;
    periph_pkg::rtc_time_t rtc_base;        // Reference time and the cycle it was valid
    int                    rtc_base_cycle;
    int                    boot_idx [8];    // Boot words written in the RAM test

    periph_top #(
        .TicksPerSecond (TicksPerSecond),
        .BootWords      (BootWords)
    ) periph_top_inst (
        .clk_i          (clk_i),
        .arst_n_i       (arst_n_i),
        .req_i          (req_i),
        .req_payload_i  (req_payload_i),
        .rvalid_o       (rvalid_o),
        .rdata_o        (rdata_o),
        .err_o          (err_o),
        .dip_switches_i (dip_switches_i),
        .leds_o         (leds_o)
    );

    initial
    begin
        clk_i = 1'b0;
        forever #2 clk_i = ~clk_i;
    end

    // Run limit
    initial
    begin
        cycles = 0;
        while (cycles < TimeoutCycles)
        begin
            @(posedge clk_i);
            cycles++;
        end
        $display("timeout: the tests did not finish within %0d cycles", TimeoutCycles);
        $display("test failed");
        $finish;
    end

    // ------------------------------------------------------------
    // Random numbers and reference models
    // ------------------------------------------------------------
    function automatic logic [63:0] random_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int i = 0; i < n; i++)
        begin
            v = {v[62:0], lfsr_state[0]};
            lfsr_state = {1'b0, lfsr_state[31:1]} ^ (lfsr_state[0] ? LfsrMask : 32'h0);
        end
        return v;
    endfunction

    function automatic periph_pkg::region_e region_of(input periph_pkg::addr_t a);
        if (a >= periph_pkg::BootBase && a < periph_pkg::BootBase + periph_pkg::BootLength)
        begin
            return periph_pkg::REGION_BOOT;
        end
        if (a >= periph_pkg::GpioBase && a < periph_pkg::GpioBase + periph_pkg::GpioLength)
        begin
            return periph_pkg::REGION_GPIO;
        end
        return periph_pkg::REGION_NONE;
    endfunction

    // Time after k more ticks with carry into seconds
    function automatic periph_pkg::rtc_time_t add_ticks(input periph_pkg::rtc_time_t t,
                                                        input int k);
        periph_pkg::rtc_time_t r;
        longint                total;
        total     = longint'(t.ticks) + longint'(k);
        r.seconds = t.seconds + periph_pkg::RtcSecBits'(total / TicksPerSecond);
        r.ticks   = periph_pkg::RtcTickBits'(total % TicksPerSecond);
        return r;
    endfunction

    function automatic periph_pkg::addr_t boot_addr(input int idx);
        return periph_pkg::BootBase + periph_pkg::addr_t'(idx * 8);
    endfunction

    function automatic periph_pkg::addr_t gpio_addr(input periph_pkg::gpio_off_t off);
        return periph_pkg::GpioBase | {26'h0, off, 3'b000};
    endfunction

    // ------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------
    task automatic check_data(input string name, input periph_pkg::data_t exp,
                              input periph_pkg::data_t act);
        if (act !== exp)
        begin
            $display("error at %0t: %s expected %h, got %h", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("error at %0t: %s expected %b, got %b", $time, name, exp, act);
            error_count++;
        end
    endtask

    task automatic check_leds(input logic [7:0] exp, input logic [7:0] act);
        if (act !== exp)
        begin
            $display("error at %0t: leds_o expected %h, got %h", $time, exp, act);
            error_count++;
        end
    endtask

    // ------------------------------------------------------------
    // Bus driving
    // ------------------------------------------------------------
    // One clock; checks the response to whatever was driven before the edge
    task automatic tick();
        logic sent;
        sent = req_i;
        @(posedge clk_i);
        #1;
        if (sent && pending.kind == EXP_LOAD)
        begin
            rtc_base       = periph_pkg::rtc_time_t'(pending.data);
            rtc_base_cycle = cycles;
        end
        if (sent && !rvalid_o)
        begin
            $display("no response to the request sampled before time %0t", $time);
            error_count++;
        end
        else if (sent)
        begin
            check_flag("err_o", pending.err, err_o);
            case (pending.kind)
                EXP_DATA: check_data("rdata_o", pending.data, rdata_o);
                EXP_RTC:  check_data("rdata_o",
                                     add_ticks(rtc_base, cycles - rtc_base_cycle), rdata_o);
                default:  ;
            endcase
        end
        else if (rvalid_o)
        begin
            $display("response at time %0t without any request", $time);
            error_count++;
        end
        req_i = 1'b0;
    endtask

    task automatic idle();
        req_i = 1'b0;
        tick();
    endtask

    task automatic send(input logic we, input periph_pkg::addr_t addr,
                        input periph_pkg::strb_t be, input periph_pkg::data_t wdata);
        periph_pkg::region_e   region;
        periph_pkg::gpio_off_t off;
        int                    idx;
        region       = region_of(addr);
        off          = addr[5:3];
        idx          = int'(addr >> 3) % BootWords;    // Depth wraps
        pending.err  = (region == periph_pkg::REGION_NONE);
        pending.kind = we ? EXP_WRITE : EXP_DATA;
        pending.data = '0;
        if (we && region == periph_pkg::REGION_BOOT)
        begin
            for (int i = 0; i < periph_pkg::StrbWidth; i++)
            begin
                if (be[i])
                begin
                    boot_model[idx][8*i +: 8] = wdata[8*i +: 8];
                end
            end
        end
        else if (we && region == periph_pkg::REGION_GPIO)
        begin
            if (off == periph_pkg::GpioRegLeds && be[0])
            begin
                leds_model = wdata[7:0];
            end
            else if (off == periph_pkg::GpioRegRtc)
            begin
                pending.kind = EXP_LOAD;
                pending.data = wdata;
            end
        end
        else if (!we)
        begin
            case (region)
                periph_pkg::REGION_BOOT: pending.data = boot_model[idx];
                periph_pkg::REGION_GPIO:
                begin
                    if (off == periph_pkg::GpioRegLeds)
                    begin
                        pending.data[7:0] = dip_switches_i;     // Upper bits stay zero
                    end
                    else if (off == periph_pkg::GpioRegRtc)
                    begin
                        pending.kind = EXP_RTC;     // Value known only in the response cycle
                    end
                end
                default: pending.data = periph_pkg::ErrorData;
            endcase
        end
        req_payload_i.we    = we;
        req_payload_i.addr  = addr;
        req_payload_i.be    = be;
        req_payload_i.wdata = wdata;
        req_i               = 1'b1;
        tick();
    endtask

    task automatic wr(input periph_pkg::addr_t addr, input periph_pkg::strb_t be,
                      input periph_pkg::data_t wdata);
        send(1'b1, addr, be, wdata);
    endtask

    task automatic rd(input periph_pkg::addr_t addr);
        send(1'b0, addr, '0, '0);
    endtask

    // ------------------------------------------------------------
    // Directed tests
    // ------------------------------------------------------------
    task automatic test_reset_state();
        check_leds(8'h00, leds_o);
        check_flag("rvalid_o", 1'b0, rvalid_o);
        check_flag("err_o", 1'b0, err_o);
        repeat (4) idle();
        rd(gpio_addr(periph_pkg::GpioRegRtc));   // Time counted since reset release
    endtask

    task automatic test_boot_ram();
        for (int i = 0; i < 8; i++)
        begin
            boot_idx[i] = int'(random_bits(9));
            wr(boot_addr(boot_idx[i]), 8'hff, random_bits(64));
        end
        for (int i = 0; i < 8; i++)
        begin
            wr(boot_addr(boot_idx[i]), 8'(random_bits(8)), random_bits(64));
        end
        for (int i = 0; i < 8; i++)
        begin
            rd(boot_addr(boot_idx[i]));
        end
        rd(boot_addr(boot_idx[0]) + 32'h0000_1000);  // Alias one depth higher
    endtask

    task automatic test_unmapped();
        rd(32'h2000_0000);
        rd(32'h0002_0000);
        rd(32'h4000_1000);
        rd(32'h0000_fff8);
        wr(32'h0003_0000 + periph_pkg::addr_t'(boot_idx[2] * 8), 8'hff, random_bits(64));
        wr(32'h4000_1000, 8'h01, random_bits(64));
        rd(boot_addr(boot_idx[2]));
        check_leds(leds_model, leds_o);
    endtask

    task automatic test_gpio();
        dip_switches_i = 8'(random_bits(8));
        wr(gpio_addr(periph_pkg::GpioRegLeds), 8'h01, random_bits(64));
        check_leds(leds_model, leds_o);
        rd(gpio_addr(periph_pkg::GpioRegLeds));
        wr(gpio_addr(periph_pkg::GpioRegLeds), 8'hfe, random_bits(64));  // Lane 0 off
        check_leds(leds_model, leds_o);
        dip_switches_i = 8'(random_bits(8));
        rd(gpio_addr(periph_pkg::GpioRegLeds));
        rd(gpio_addr(3'd3));
    endtask

    task automatic test_rtc();
        int                k_values [6] = '{1, 2, 3, 4, 9, 23};
        periph_pkg::data_t load;
        foreach (k_values[j])
        begin
            load = {periph_pkg::RtcSecBits'(random_bits(periph_pkg::RtcSecBits)),
                    periph_pkg::RtcTickBits'(TicksPerSecond - 2)};
            wr(gpio_addr(periph_pkg::GpioRegRtc), 8'hff, load);
            repeat (k_values[j] - 1) idle();
            rd(gpio_addr(periph_pkg::GpioRegRtc));
        end
    endtask

    task automatic test_back_to_back();
        wr(boot_addr(boot_idx[3]), 8'hff, random_bits(64));
        rd(boot_addr(boot_idx[3]));
        wr(gpio_addr(periph_pkg::GpioRegLeds), 8'h01, random_bits(64));
        rd(gpio_addr(periph_pkg::GpioRegLeds));
        rd(gpio_addr(periph_pkg::GpioRegRtc));
        rd(32'h8000_0000);
        wr(32'h8000_0008, 8'hff, random_bits(64));
        rd(boot_addr(boot_idx[1]));
        wr(gpio_addr(periph_pkg::GpioRegRtc), 8'hff,
           {periph_pkg::RtcSecBits'(random_bits(periph_pkg::RtcSecBits)),
            periph_pkg::RtcTickBits'(TicksPerSecond - 1)});
        rd(gpio_addr(periph_pkg::GpioRegRtc));
        rd(gpio_addr(3'd2));
        wr(boot_addr(boot_idx[1]), 8'h0f, random_bits(64));
        rd(boot_addr(boot_idx[1]));
        idle();
        check_leds(leds_model, leds_o);
    endtask

    // ------------------------------------------------------------
    // Main sequence
    // ------------------------------------------------------------
    initial
    begin
        error_count    = 0;
        lfsr_state     = LfsrSeed;
        pending        = '0;
        leds_model     = 8'h00;
        rtc_base       = '0;
        rtc_base_cycle = 0;
        arst_n_i       = 1'b0;
        req_i          = 1'b0;
        req_payload_i  = '0;
        dip_switches_i = 8'h00;
        repeat (5) @(posedge clk_i);
        #1;
        arst_n_i       = 1'b1;
        rtc_base_cycle = cycles;    // Time is zero here and counts from the next edge

        test_reset_state();
        test_boot_ram();
        test_unmapped();
        test_gpio();
        test_rtc();
        test_back_to_back();

        $display("tests done with %0d errors", error_count);
        if (error_count == 0)
        begin
            $display("test passed");
        end
        else
        begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
periph_pkg.sv
rtc_timer.sv
boot_ram.sv
gpio_regs.sv
bus_decoder.sv
periph_top.sv
tb_periph_top.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_periph_top -f src.f || exit 1
sim_out="$(./obj_dir/Vtb_periph_top)"
echo "$sim_out"
echo "$sim_out" | grep -qx "test passed" && exit 0 || exit 1
